/* all.f */
logic/mipsPkg.sv
logic/regFile.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memWbStage.sv
logic/hazardUnit.sv
logic/mipsCore.sv
verif/coreTb.sv

/* logic/decodeStage.sv */
// --------------------------------------------------
// decode, branch compare and decode/execute register
// beq only forwards from memory, writeback goes via regfile
// --------------------------------------------------
module decodeStage (
	input  logic             clk,
	input  logic             rst,
	input  logic             flushE,
	input  mipsPkg::word_t   instrD,
	input  mipsPkg::word_t   pcPlus4D,
	input  logic             forwardAD,
	input  logic             forwardBD,
	input  mipsPkg::word_t   aluoutM,
	input  mipsPkg::word_t   resultW,
	input  mipsPkg::regIdx_t writeregW,
	input  logic             regwriteW,
	output mipsPkg::regIdx_t rsD,
	output mipsPkg::regIdx_t rtD,
	output logic             branchD,
	output logic             jumpD,
	output logic             pcsrcD,
	output mipsPkg::word_t   branchTarget,
	output mipsPkg::word_t   jumpTarget,
	output mipsPkg::word_t   srcAE,
	output mipsPkg::word_t   srcBE,
	output mipsPkg::word_t   immE,
	output mipsPkg::regIdx_t rsE,
	output mipsPkg::regIdx_t rtE,
	output mipsPkg::regIdx_t writeregE,
	output mipsPkg::aluOp_t  aluOpE,
	output logic             aluSrcE,
	output logic             regwriteE,
	output logic             memtoregE,
	output logic             memwriteE
);
	import mipsPkg::*;

	opcode_t opD;
	funct_t  functD;
	regIdx_t rdD;
	regIdx_t writeregD;
	word_t   immD;
	word_t   rdA;
	word_t   rdB;
	word_t   cmpA;
	word_t   cmpB;
	aluOp_t  aluOpD;
	logic    aluSrcD;
	logic    regDstD;
	logic    regwriteD;
	logic    memtoregD;
	logic    memwriteD;

	// instruction fields
	assign opD    = instrD[31:26];
	assign rsD    = instrD[25:21];
	assign rtD    = instrD[20:16];
	assign rdD    = instrD[15:11];
	assign functD = instrD[5:0];
	// sign-extended immediate
	assign immD   = {{16{instrD[15]}}, instrD[15:0]};

	regFile regFile_i (
		.clk       (clk),
		.writeEn   (regwriteW),
		.writeReg  (writeregW),
		.writeData (resultW),
		.readRegA  (rsD),
		.readRegB  (rtD),
		.readDataA (rdA),
		.readDataB (rdB)
	);

	// control decode, unknown encodings do nothing
	always_comb begin
		aluOpD    = ALU_ADD;
		aluSrcD   = 1'b0;
		regDstD   = 1'b0;
		regwriteD = 1'b0;
		memtoregD = 1'b0;
		memwriteD = 1'b0;
		branchD   = 1'b0;
		jumpD     = 1'b0;
		case (opD)
			OP_RTYPE: begin
				regDstD = 1'b1;
				// the all-zero nop falls through with no write
				regwriteD = 1'b1;
				case (functD)
					FN_ADD: aluOpD = ALU_ADD;
					FN_SUB: aluOpD = ALU_SUB;
					FN_AND: aluOpD = ALU_AND;
					FN_OR:  aluOpD = ALU_OR;
					FN_SLT: aluOpD = ALU_SLT;
					default: regwriteD = 1'b0;
				endcase
			end
			OP_ADDI: begin
				aluSrcD   = 1'b1;
				regwriteD = 1'b1;
			end
			OP_LW: begin
				aluSrcD   = 1'b1;
				regwriteD = 1'b1;
				memtoregD = 1'b1;
			end
			OP_SW: begin
				aluSrcD   = 1'b1;
				memwriteD = 1'b1;
			end
			OP_BEQ: branchD = 1'b1;
			OP_J:   jumpD   = 1'b1;
			default: ;
		endcase
	end

	assign writeregD = regDstD ? rdD : rtD;

	// early branch compare, memory-stage result bypassed in
	assign cmpA   = forwardAD ? aluoutM : rdA;
	assign cmpB   = forwardBD ? aluoutM : rdB;
	assign pcsrcD = branchD && (cmpA == cmpB);

	assign branchTarget = pcPlus4D + {immD[29:0], 2'b00};
	// jump keeps the top nibble of pc+4
	assign jumpTarget   = {pcPlus4D[31:28], instrD[25:0], 2'b00};

	// decode/execute register, bubble on flush
	always_ff @(posedge clk) begin
		if (rst || flushE) begin
			aluOpE    <= ALU_ADD;
			aluSrcE   <= 1'b0;
			regwriteE <= 1'b0;
			memtoregE <= 1'b0;
			memwriteE <= 1'b0;
			// cleared so a bubble never matches a hazard compare
			rsE       <= '0;
			rtE       <= '0;
			writeregE <= '0;
		end else begin
			aluOpE    <= aluOpD;
			aluSrcE   <= aluSrcD;
			regwriteE <= regwriteD;
			memtoregE <= memtoregD;
			memwriteE <= memwriteD;
			rsE       <= rsD;
			rtE       <= rtD;
			writeregE <= writeregD;
		end
	end

	// operand payload
	always_ff @(posedge clk) begin
		srcAE <= rdA;
		srcBE <= rdB;
		immE  <= immD;
	end

endmodule : decodeStage

/* logic/executeStage.sv */
// --------------------------------------------------
// operand forwarding, alu and execute/memory register
// slt is a signed compare
// --------------------------------------------------
module executeStage (
	input  logic              clk,
	input  logic              rst,
	input  mipsPkg::word_t    srcAE,
	input  mipsPkg::word_t    srcBE,
	input  mipsPkg::word_t    immE,
	input  mipsPkg::regIdx_t  rtE,
	input  mipsPkg::regIdx_t  writeregE,
	input  mipsPkg::aluOp_t   aluOpE,
	input  logic              aluSrcE,
	input  logic              regwriteE,
	input  logic              memtoregE,
	input  logic              memwriteE,
	input  mipsPkg::fwdSel_t  forwardAE,
	input  mipsPkg::fwdSel_t  forwardBE,
	input  mipsPkg::word_t    resultW,
	output mipsPkg::word_t    aluoutM,
	output mipsPkg::word_t    writeDataM,
	output mipsPkg::regIdx_t  writeregM,
	output logic              regwriteM,
	output logic              memtoregM,
	output logic              memwriteM
);
	import mipsPkg::*;

	word_t opA;
	word_t fwdB;
	word_t opB;
	word_t aluoutE;

	// forwarding muxes, memory stage has the newer value
	always_comb begin
		case (forwardAE)
			FWD_MEM: opA = aluoutM;
			FWD_WB:  opA = resultW;
			default: opA = srcAE;
		endcase
		case (forwardBE)
			FWD_MEM: fwdB = aluoutM;
			FWD_WB:  fwdB = resultW;
			default: fwdB = srcBE;
		endcase
	end

	// forwarded rt is also the store data
	assign opB = aluSrcE ? immE : fwdB;

	always_comb begin
		case (aluOpE)
			ALU_SUB: aluoutE = opA - opB;
			ALU_AND: aluoutE = opA & opB;
			ALU_OR:  aluoutE = opA | opB;
			ALU_SLT: aluoutE = {31'd0, $signed(opA) < $signed(opB)};
			default: aluoutE = opA + opB;
		endcase
	end

	// execute/memory control
	always_ff @(posedge clk) begin
		if (rst) begin
			regwriteM <= 1'b0;
			memtoregM <= 1'b0;
			memwriteM <= 1'b0;
			writeregM <= '0;
		end else begin
			regwriteM <= regwriteE;
			memtoregM <= memtoregE;
			memwriteM <= memwriteE;
			writeregM <= writeregE;
		end
	end

	// result and store data
	always_ff @(posedge clk) begin
		aluoutM    <= aluoutE;
		writeDataM <= fwdB;
	end

endmodule : executeStage

/* logic/fetchStage.sv */
// --------------------------------------------------
// pc and fetch/decode register
// imemData must be valid in the cycle imemAddr is set
// --------------------------------------------------
module fetchStage (
	input  logic           clk,
	input  logic           rst,
	input  logic           stallF,
	input  logic           stallD,
	input  logic           flushD,
	input  logic           pcsrcD,
	input  logic           jumpD,
	input  mipsPkg::word_t branchTarget,
	input  mipsPkg::word_t jumpTarget,
	output mipsPkg::word_t imemAddr,
	input  mipsPkg::word_t imemData,
	output mipsPkg::word_t instrD,
	output mipsPkg::word_t pcPlus4D
);
	import mipsPkg::*;

	word_t pcF;
	word_t pcPlus4F;
	word_t pcNext;

	assign pcPlus4F = pcF + 32'd4;

	// redirect comes from decode, jump wins over branch
	always_comb begin
		if (jumpD)
			pcNext = jumpTarget;
		else if (pcsrcD)
			pcNext = branchTarget;
		else
			pcNext = pcPlus4F;
	end

	// pc holds while fetch is stalled
	always_ff @(posedge clk) begin
		if (rst)
			pcF <= RESET_PC;
		else if (!stallF)
			pcF <= pcNext;
	end

	assign imemAddr = pcF;

	// fetch/decode register
	// stall holds it, flush drops the wrong-path fetch
	always_ff @(posedge clk) begin
		if (rst) begin
			instrD   <= NOP_INSTR;
			pcPlus4D <= RESET_PC;
		end else if (!stallD) begin
			if (flushD)
				instrD <= NOP_INSTR;
			else
				instrD <= imemData;
			pcPlus4D <= pcPlus4F;
		end
	end

endmodule : fetchStage

/* logic/hazardUnit.sv */
// --------------------------------------------------
// forwarding selects, stalls and flushes
// branches resolve in decode, purely combinational
// --------------------------------------------------
module hazardUnit (
	input  logic              branchD,
	input  logic              jumpD,
	input  logic              pcsrcD,
	input  mipsPkg::regIdx_t  rsD,
	input  mipsPkg::regIdx_t  rtD,
	input  mipsPkg::regIdx_t  rsE,
	input  mipsPkg::regIdx_t  rtE,
	input  mipsPkg::regIdx_t  writeregE,
	input  logic              memtoregE,
	input  logic              regwriteE,
	input  mipsPkg::regIdx_t  writeregM,
	input  logic              memtoregM,
	input  logic              regwriteM,
	input  mipsPkg::regIdx_t  writeregW,
	input  logic              regwriteW,
	output logic              forwardAD,
	output logic              forwardBD,
	output mipsPkg::fwdSel_t  forwardAE,
	output mipsPkg::fwdSel_t  forwardBE,
	output logic              stallF,
	output logic              stallD,
	output logic              flushD,
	output logic              flushE
);
	import mipsPkg::*;

	logic lwStall;
	logic branchStall;

	// source select for one execute operand
	function automatic fwdSel_t execFwd(input regIdx_t src);
		// r0 is constant, never forward it
		if (src == '0)
			return FWD_REG;
		// memory stage is younger, so it wins
		if (regwriteM && (src == writeregM))
			return FWD_MEM;
		if (regwriteW && (src == writeregW))
			return FWD_WB;
		return FWD_REG;
	endfunction

	always_comb begin
		forwardAE = execFwd(rsE);
		forwardBE = execFwd(rtE);
	end

	// branch compare bypass from the memory stage
	// a writeback value already comes through the regfile
	assign forwardAD = (rsD != '0) && regwriteM && (rsD == writeregM);
	assign forwardBD = (rtD != '0) && regwriteM && (rtD == writeregM);

	// load in execute feeding the instruction in decode
	assign lwStall = memtoregE && ((rsD == rtE) || (rtD == rtE));

	// branch operands not ready yet
	// alu result still in execute, or load data still in memory
	always_comb begin
		branchStall = 1'b0;
		if (branchD) begin
			if (regwriteE && ((writeregE == rsD) || (writeregE == rtD)))
				branchStall = 1'b1;
			if (memtoregM && ((writeregM == rsD) || (writeregM == rtD)))
				branchStall = 1'b1;
		end
	end

	// both stalls freeze fetch and decode and bubble execute
	assign stallF = lwStall | branchStall;
	assign stallD = lwStall | branchStall;
	assign flushE = lwStall | branchStall;

	// drop the fall-through fetch after a redirect
	assign flushD = pcsrcD | jumpD;

endmodule : hazardUnit

/* logic/memWbStage.sv */
// --------------------------------------------------
// data memory and memory/writeback register
// address bits above the array size are ignored
// --------------------------------------------------
module memWbStage (
	input  logic             clk,
	input  logic             rst,
	input  mipsPkg::word_t   aluoutM,
	input  mipsPkg::word_t   writeDataM,
	input  mipsPkg::regIdx_t writeregM,
	input  logic             regwriteM,
	input  logic             memtoregM,
	input  logic             memwriteM,
	output mipsPkg::word_t   resultW,
	output mipsPkg::regIdx_t writeregW,
	output logic             regwriteW
);
	import mipsPkg::*;

	word_t dmem [DMEM_WORDS];

	logic [DMEM_AW-1:0] wordAddr;
	word_t readDataM;
	word_t readDataW;
	word_t aluoutW;
	logic  memtoregW;

	// byte address to word index
	assign wordAddr = aluoutM[DMEM_AW+1:2];

	// store at the edge, load read combinationally
	always_ff @(posedge clk) begin
		if (memwriteM)
			dmem[wordAddr] <= writeDataM;
	end

	assign readDataM = dmem[wordAddr];

	// memory/writeback control
	always_ff @(posedge clk) begin
		if (rst) begin
			regwriteW <= 1'b0;
			memtoregW <= 1'b0;
			writeregW <= '0;
		end else begin
			regwriteW <= regwriteM;
			memtoregW <= memtoregM;
			writeregW <= writeregM;
		end
	end

	always_ff @(posedge clk) begin
		readDataW <= readDataM;
		aluoutW   <= aluoutM;
	end

	// load data or alu result
	assign resultW = memtoregW ? readDataW : aluoutW;

endmodule : memWbStage

/* logic/mipsCore.sv */
// --------------------------------------------------
// core top, instruction memory lives outside
// writes to r0 never show on the retire port
// --------------------------------------------------
module mipsCore (
	input  logic             clk,
	input  logic             rst,
	output mipsPkg::word_t   imemAddr,
	input  mipsPkg::word_t   imemData,
	output logic             wbValid,
	output mipsPkg::regIdx_t wbReg,
	output mipsPkg::word_t   wbData
);
	import mipsPkg::*;

	// hazard controls
	logic    stallF, stallD, flushD, flushE;
	logic    forwardAD, forwardBD;
	fwdSel_t forwardAE, forwardBE;

	// fetch to decode and back
	word_t   instrD, pcPlus4D;
	word_t   branchTarget, jumpTarget;
	logic    branchD, jumpD, pcsrcD;
	regIdx_t rsD, rtD;

	// decode to execute
	word_t   srcAE, srcBE, immE;
	regIdx_t rsE, rtE, writeregE;
	aluOp_t  aluOpE;
	logic    aluSrcE, regwriteE, memtoregE, memwriteE;

	// execute to memory
	word_t   aluoutM, writeDataM;
	regIdx_t writeregM;
	logic    regwriteM, memtoregM, memwriteM;

	// writeback
	word_t   resultW;
	regIdx_t writeregW;
	logic    regwriteW;

	fetchStage fetchStage_i (
		.clk (clk), .rst (rst),
		.stallF (stallF), .stallD (stallD), .flushD (flushD),
		.pcsrcD (pcsrcD), .jumpD (jumpD),
		.branchTarget (branchTarget), .jumpTarget (jumpTarget),
		.imemAddr (imemAddr), .imemData (imemData),
		.instrD (instrD), .pcPlus4D (pcPlus4D)
	);

	decodeStage decodeStage_i (
		.clk (clk), .rst (rst), .flushE (flushE),
		.instrD (instrD), .pcPlus4D (pcPlus4D),
		.forwardAD (forwardAD), .forwardBD (forwardBD), .aluoutM (aluoutM),
		.resultW (resultW), .writeregW (writeregW), .regwriteW (regwriteW),
		.rsD (rsD), .rtD (rtD), .branchD (branchD), .jumpD (jumpD), .pcsrcD (pcsrcD),
		.branchTarget (branchTarget), .jumpTarget (jumpTarget),
		.srcAE (srcAE), .srcBE (srcBE), .immE (immE),
		.rsE (rsE), .rtE (rtE), .writeregE (writeregE),
		.aluOpE (aluOpE), .aluSrcE (aluSrcE), .regwriteE (regwriteE),
		.memtoregE (memtoregE), .memwriteE (memwriteE)
	);

	executeStage executeStage_i (
		.clk (clk), .rst (rst),
		.srcAE (srcAE), .srcBE (srcBE), .immE (immE),
		.rtE (rtE), .writeregE (writeregE), .aluOpE (aluOpE), .aluSrcE (aluSrcE),
		.regwriteE (regwriteE), .memtoregE (memtoregE), .memwriteE (memwriteE),
		.forwardAE (forwardAE), .forwardBE (forwardBE), .resultW (resultW),
		.aluoutM (aluoutM), .writeDataM (writeDataM), .writeregM (writeregM),
		.regwriteM (regwriteM), .memtoregM (memtoregM), .memwriteM (memwriteM)
	);

	memWbStage memWbStage_i (
		.clk (clk), .rst (rst),
		.aluoutM (aluoutM), .writeDataM (writeDataM), .writeregM (writeregM),
		.regwriteM (regwriteM), .memtoregM (memtoregM), .memwriteM (memwriteM),
		.resultW (resultW), .writeregW (writeregW), .regwriteW (regwriteW)
	);

	hazardUnit hazardUnit_i (
		.branchD (branchD), .jumpD (jumpD), .pcsrcD (pcsrcD),
		.rsD (rsD), .rtD (rtD), .rsE (rsE), .rtE (rtE),
		.writeregE (writeregE), .memtoregE (memtoregE), .regwriteE (regwriteE),
		.writeregM (writeregM), .memtoregM (memtoregM), .regwriteM (regwriteM),
		.writeregW (writeregW), .regwriteW (regwriteW),
		.forwardAD (forwardAD), .forwardBD (forwardBD),
		.forwardAE (forwardAE), .forwardBE (forwardBE),
		.stallF (stallF), .stallD (stallD), .flushD (flushD), .flushE (flushE)
	);

	// retire port, r0 writes are not real results
	assign wbValid = regwriteW && (writeregW != '0);
	assign wbReg   = writeregW;
	assign wbData  = resultW;

endmodule : mipsCore

/* logic/mipsPkg.sv */
// --------------------------------------------------
// shared types and constants for the 5-stage core
// data memory is word addressed, byte offsets ignored
// --------------------------------------------------
package mipsPkg;

	// data and address word
	typedef logic [31:0] word_t;
	// register number
	typedef logic [4:0] regIdx_t;
	// primary opcode and funct field
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	// execute operand source
	typedef enum logic [1:0] {
		FWD_REG,
		FWD_WB,
		FWD_MEM
	} fwdSel_t;

	// alu operations used by the supported instructions
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} aluOp_t;

	// primary opcodes
	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_J     = 6'h02;
	localparam opcode_t OP_BEQ   = 6'h04;
	localparam opcode_t OP_ADDI  = 6'h08;
	localparam opcode_t OP_LW    = 6'h23;
	localparam opcode_t OP_SW    = 6'h2b;

	// r-type funct codes
	localparam funct_t FN_ADD = 6'h20;
	localparam funct_t FN_SUB = 6'h22;
	localparam funct_t FN_AND = 6'h24;
	localparam funct_t FN_OR  = 6'h25;
	localparam funct_t FN_SLT = 6'h2a;

	// all-zero word, decodes to no write
	localparam word_t NOP_INSTR = 32'h0000_0000;
	localparam word_t RESET_PC  = 32'h0000_0000;

	// data memory size in words
	localparam int DMEM_WORDS = 256;
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);

endpackage : mipsPkg

/* logic/regFile.sv */
// --------------------------------------------------
// 32 x 32 register file, r0 reads zero
// same-cycle write is visible on both read ports
// --------------------------------------------------
module regFile (
	input  logic             clk,
	input  logic             writeEn,
	input  mipsPkg::regIdx_t writeReg,
	input  mipsPkg::word_t   writeData,
	input  mipsPkg::regIdx_t readRegA,
	input  mipsPkg::regIdx_t readRegB,
	output mipsPkg::word_t   readDataA,
	output mipsPkg::word_t   readDataB
);
	import mipsPkg::*;

	word_t regs [32];

	// one read port, write-first
	function automatic word_t readPort(input regIdx_t idx);
		if (idx == '0)
			return '0;
		// bypass the value being written this edge
		if (writeEn && (writeReg == idx))
			return writeData;
		return regs[idx];
	endfunction

	// r0 is never stored
	always_ff @(posedge clk) begin
		if (writeEn && (writeReg != '0))
			regs[writeReg] <= writeData;
	end

	always_comb begin
		readDataA = readPort(readRegA);
		readDataB = readPort(readRegB);
	end

endmodule : regFile

/* verif/coreTb.sv */
// --------------------------------------------------
// directed tests, checked on the retire port only
// registers and data memory are not reset, tests write before read
// --------------------------------------------------
module coreTb;
	timeunit 1ns;
	timeprecision 1ps;
	import mipsPkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int DRIVE_DELAY  = 10;
	localparam int RESET_CYCLES = 16;
	localparam int DRAIN_CYCLES = 10;
	localparam int CYCLE_LIMIT  = 2000;
	localparam int IMEM_WORDS   = 64;

	logic    clk;
	logic    rst;
	word_t   imemAddr;
	word_t   imemData;
	logic    wbValid;
	regIdx_t wbReg;
	word_t   wbData;

	// program store and sequential model state
	word_t imem [IMEM_WORDS];
	word_t shadow [32];
	word_t shadowMem [DMEM_WORDS];
	int    progLen = 0;

	// expected and observed retire streams
	regIdx_t expReg[$];
	word_t   expData[$];
	regIdx_t gotReg[$];
	word_t   gotData[$];
	int      gotCycle[$];

	int          cycleCount = 0;
	int          startCycle = 0;
	int          errors = 0;
	int          checks = 0;
	logic [31:0] lcgState = 32'h0362_9715;

	mipsCore mipsCore_i (
		.clk      (clk),
		.rst      (rst),
		.imemAddr (imemAddr),
		.imemData (imemData),
		.wbValid  (wbValid),
		.wbReg    (wbReg),
		.wbData   (wbData)
	);

	// combinational fetch, anything past the store reads as nop
	assign imemData = (imemAddr[31:2] < IMEM_WORDS) ? imem[imemAddr[31:2]] : NOP_INSTR;

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// cycle count, also the run limit
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("timeout: no finish after %0d cycles, %0d errors", cycleCount, errors);
			$display("TEST FAILED");
			$finish;
		end
	end

	// retire monitor, sampled mid-cycle
	always @(negedge clk) begin
		if (!rst && wbValid) begin
			gotReg.push_back(wbReg);
			gotData.push_back(wbData);
			gotCycle.push_back(cycleCount);
		end
	end

	task automatic check(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState;
	endfunction

	// instruction formats
	function automatic word_t rFormat(input funct_t fn, input regIdx_t rd,
		input regIdx_t rs, input regIdx_t rt);
		return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t iFormat(input opcode_t op, input regIdx_t rt,
		input regIdx_t rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jFormat(input int index);
		return {OP_J, 26'(index)};
	endfunction

	function automatic word_t sext(input logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	task automatic place(input word_t instr);
		imem[progLen] = instr;
		progLen++;
	endtask

	// r0 stays zero and never retires
	task automatic expectWrite(input regIdx_t rd, input word_t value);
		if (rd != '0) begin
			shadow[rd] = value;
			expReg.push_back(rd);
			expData.push_back(value);
		end
	endtask

	// live is low for instructions on a skipped path
	task automatic aluInstr(input funct_t fn, input regIdx_t rd, input regIdx_t rs,
		input regIdx_t rt, input bit live);
		word_t a;
		word_t b;
		word_t r;
		a = shadow[rs];
		b = shadow[rt];
		case (fn)
			FN_SUB: r = a - b;
			FN_AND: r = a & b;
			FN_OR:  r = a | b;
			FN_SLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: r = a + b;
		endcase
		place(rFormat(fn, rd, rs, rt));
		if (live)
			expectWrite(rd, r);
	endtask

	task automatic addiInstr(input regIdx_t rt, input regIdx_t rs, input logic [15:0] imm,
		input bit live);
		place(iFormat(OP_ADDI, rt, rs, imm));
		if (live)
			expectWrite(rt, shadow[rs] + sext(imm));
	endtask

	task automatic loadInstr(input regIdx_t rt, input regIdx_t rs, input logic [15:0] imm);
		word_t addr;
		addr = shadow[rs] + sext(imm);
		place(iFormat(OP_LW, rt, rs, imm));
		expectWrite(rt, shadowMem[(addr >> 2) % DMEM_WORDS]);
	endtask

	task automatic storeInstr(input regIdx_t rt, input regIdx_t rs, input logic [15:0] imm);
		word_t addr;
		addr = shadow[rs] + sext(imm);
		place(iFormat(OP_SW, rt, rs, imm));
		shadowMem[(addr >> 2) % DMEM_WORDS] = shadow[rt];
	endtask

	// offset in words from the following instruction
	task automatic branchInstr(input regIdx_t rs, input regIdx_t rt, input int offset);
		place(iFormat(OP_BEQ, rt, rs, 16'(offset)));
	endtask

	task automatic jumpInstr(input int index);
		place(jFormat(index));
	endtask

	// hold reset and clear program and model
	task automatic beginProgram(input string title);
		@(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b1;
		$display("running %s", title);
		foreach (imem[i])
			imem[i] = NOP_INSTR;
		foreach (shadow[i])
			shadow[i] = '0;
		expReg.delete();
		expData.delete();
		gotReg.delete();
		gotData.delete();
		gotCycle.delete();
		progLen = 0;
	endtask

	task automatic runProgram();
		int n;
		// self-branch parks the core once the program is done
		branchInstr(5'd0, 5'd0, -1);
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		// fetch starts at the reset pc
		check("imemAddr", imemAddr, RESET_PC);
		// cycle in which the first instruction is fetched
		startCycle = cycleCount;
		while (gotReg.size() < expReg.size())
			@(posedge clk);
		// extra writes after this would be wrong-path retires
		repeat (DRAIN_CYCLES) @(posedge clk);
		check("retire count", gotReg.size(), expReg.size());
		for (n = 0; n < expReg.size() && n < gotReg.size(); n++) begin
			check($sformatf("wbReg #%0d", n), 32'(gotReg[n]), 32'(expReg[n]));
			check($sformatf("wbData #%0d", n), gotData[n], expData[n]);
		end
	endtask

	task automatic testIndependent();
		logic [31:0] rnd;
		int r;
		beginProgram("independent addi and latency");
		for (r = 1; r <= 8; r++) begin
			rnd = lcgNext();
			addiInstr(regIdx_t'(r), 5'd0, rnd[31:16], 1'b1);
		end
		runProgram();
		if (gotCycle.size() > 0)
			check("retire latency", 32'(gotCycle[0] - startCycle), 32'd4);
	endtask

	task automatic testForwarding();
		beginProgram("alu forwarding chain");
		addiInstr(5'd1, 5'd0, 16'h0015, 1'b1);
		addiInstr(5'd2, 5'd0, 16'hfff9, 1'b1);
		// memory and writeback sources in one instruction
		aluInstr(FN_ADD, 5'd3, 5'd1, 5'd2, 1'b1);
		aluInstr(FN_SUB, 5'd4, 5'd3, 5'd1, 1'b1);
		aluInstr(FN_AND, 5'd5, 5'd4, 5'd3, 1'b1);
		aluInstr(FN_OR,  5'd6, 5'd5, 5'd4, 1'b1);
		aluInstr(FN_SLT, 5'd7, 5'd6, 5'd5, 1'b1);
		// negative operand in a signed compare
		aluInstr(FN_SLT, 5'd8, 5'd2, 5'd7, 1'b1);
		runProgram();
	endtask

	task automatic testLoadUse();
		beginProgram("store, load and load-use stall");
		addiInstr(5'd1, 5'd0, 16'h0040, 1'b1);
		addiInstr(5'd2, 5'd0, 16'h0123, 1'b1);
		storeInstr(5'd2, 5'd1, 16'h0008);
		loadInstr(5'd3, 5'd1, 16'h0008);
		aluInstr(FN_ADD, 5'd4, 5'd3, 5'd2, 1'b1);
		storeInstr(5'd4, 5'd1, 16'h000c);
		loadInstr(5'd5, 5'd1, 16'h000c);
		// both operands from the load
		aluInstr(FN_ADD, 5'd6, 5'd5, 5'd5, 1'b1);
		runProgram();
	endtask

	task automatic testBranches();
		beginProgram("taken and not-taken beq");
		addiInstr(5'd1, 5'd0, 16'h0005, 1'b1);
		addiInstr(5'd2, 5'd0, 16'h0005, 1'b1);
		// operand from the instruction just before, taken
		branchInstr(5'd1, 5'd2, 2);
		addiInstr(5'd3, 5'd0, 16'h0011, 1'b0);
		addiInstr(5'd4, 5'd0, 16'h0022, 1'b0);
		addiInstr(5'd5, 5'd0, 16'h0033, 1'b1);
		aluInstr(FN_ADD, 5'd6, 5'd5, 5'd1, 1'b1);
		// not taken, falls through
		branchInstr(5'd6, 5'd1, 1);
		addiInstr(5'd7, 5'd0, 16'h0044, 1'b1);
		runProgram();
	endtask

	task automatic testJumpAndZero();
		beginProgram("jump and register 0");
		addiInstr(5'd0, 5'd0, 16'h0055, 1'b1);
		addiInstr(5'd1, 5'd0, 16'h0007, 1'b1);
		jumpInstr(4);
		addiInstr(5'd2, 5'd0, 16'h0066, 1'b0);
		aluInstr(FN_ADD, 5'd3, 5'd1, 5'd0, 1'b1);
		aluInstr(FN_ADD, 5'd0, 5'd1, 5'd1, 1'b1);
		// r0 right after a write to it still reads zero
		aluInstr(FN_OR, 5'd4, 5'd0, 5'd1, 1'b1);
		runProgram();
	endtask

	initial begin
		rst = 1'b1;
		foreach (imem[i])
			imem[i] = NOP_INSTR;
		testIndependent();
		testForwarding();
		testLoadUse();
		testBranches();
		testJumpAndZero();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule : coreTb
